//--- include/rv_decode_params.svh
// RV32I dual decode parameters for lane count, FIFO depth and data width
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// Decoder lanes per bundle
`define RV_LANES 2

// Decoded bundles held in the output FIFO, power of two
`define RV_FIFO_DEPTH 4

// Address, instruction and immediate width
`define RV_XLEN 32

`endif

//--- hdl/rv_decode_pkg.sv
// RV32I decode types for instruction names, classes, flags, fetch slots and records
`include "rv_decode_params.svh"

package rv_decode_pkg;

  typedef enum logic [5:0] {
    LB, LH, LW, LBU, LHU,
    SB, SH, SW,
    BEQ, BNE, BLT, BGE, BLTU, BGEU,
    JAL, JALR,
    ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    LUI, AUIPC, FENCE, ECALL, EBREAK, UNKNOWN
  } instr_name_e;

  typedef enum logic [1:0] {
    LS,  // Loads and stores
    BR,  // Branches and jumps
    AL,  // Arithmetic, logic and system
    XX   // Unknown
  } instr_type_e;

  typedef struct packed {
    logic writes;
    logic jumps;
    logic mem;
    logic uses_imm;
  } instr_flags_t;

  typedef struct packed {
    logic [4:0] rd;
    logic [4:0] rs_1;
    logic [4:0] rs_2;
  } instr_regs_t;

  // One fetched instruction, 65 bits
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] address;
    logic [`RV_XLEN-1:0] instr;
  } fetch_slot_t;

  // One decoded instruction, 92 bits
  typedef struct packed {
    logic                valid;
    logic [`RV_XLEN-1:0] address;
    instr_name_e         instr_name;
    instr_type_e         instr_type;
    instr_regs_t         regs;
    logic [`RV_XLEN-1:0] immediate;
    instr_flags_t        flags;
  } instr_info_t;

endpackage

//--- hdl/fetch_bundle_reg.sv
// Fetch bundle register that captures an input bundle on the handshake and holds it on stall
`timescale 1ns/10ps
`include "rv_decode_params.svh"

module fetch_bundle_reg import rv_decode_pkg::*; (
  input  logic                          i_clock,
  input  logic                          i_rst_n,
  input  logic                          i_stall,
  input  logic                          i_bundle_valid,
  output logic                          o_bundle_ready,
  input  fetch_slot_t [`RV_LANES-1:0]   i_bundle,
  output fetch_slot_t [`RV_LANES-1:0]   o_slots
);

  assign o_bundle_ready = ~i_stall;

  // Only the slot valid bits are reset, address and word keep their value
  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      for (int k = 0; k < `RV_LANES; k++) begin
        o_slots[k].valid <= 1'b0;
      end
    end else if (!i_stall) begin
      if (i_bundle_valid) begin
        o_slots <= i_bundle;  // Transfer
      end else begin
        for (int k = 0; k < `RV_LANES; k++) begin
          o_slots[k].valid <= 1'b0;  // Bubble so a bundle decodes once
        end
      end
    end
  end

endmodule

//--- hdl/rv_decoder.sv
// Single RV32I decode lane that turns one fetch slot into a registered decoded record
`timescale 1ns/10ps
`include "rv_decode_params.svh"

module rv_decoder import rv_decode_pkg::*; (
  input  logic        i_clock,
  input  logic        i_rst_n,
  input  logic        i_stall,
  input  fetch_slot_t i_slot,
  output instr_info_t o_info
);

  logic [`RV_XLEN-1:0] word;
  logic [4:0]          opcode;
  logic [2:0]          funct3;
  logic                funct7_5;
  logic [4:0]          rd_idx;
  logic [4:0]          rs1_idx;
  logic [4:0]          rs2_idx;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_sh;
  instr_info_t         info_d;

  assign word     = i_slot.instr;
  assign opcode   = word[6:2];
  assign funct3   = word[14:12];
  assign funct7_5 = word[30];
  assign rd_idx   = word[11:7];
  assign rs1_idx  = word[19:15];
  assign rs2_idx  = word[24:20];

  assign imm_i  = {{20{word[31]}}, word[31:20]};
  assign imm_s  = {{20{word[31]}}, word[31:25], word[11:7]};
  assign imm_b  = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
  assign imm_u  = {word[31:12], 12'h000};
  assign imm_j  = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
  assign imm_sh = {27'd0, word[24:20]};  // Zero-extended shamt

  always_comb begin
    info_d            = '0;
    info_d.valid      = i_slot.valid;
    info_d.address    = i_slot.address;
    info_d.instr_name = UNKNOWN;
    info_d.instr_type = XX;
    if (word[1:0] == 2'b11) begin  // Zero word lands here as UNKNOWN
      case (opcode)
        5'b00000: begin  // LOAD
          case (funct3)
            3'b000:  info_d.instr_name = LB;
            3'b001:  info_d.instr_name = LH;
            3'b010:  info_d.instr_name = LW;
            3'b100:  info_d.instr_name = LBU;
            3'b101:  info_d.instr_name = LHU;
            default: info_d.instr_name = UNKNOWN;
          endcase
          info_d.instr_type     = LS;
          info_d.regs.rd        = rd_idx;
          info_d.regs.rs_1      = rs1_idx;
          info_d.immediate      = imm_i;
          info_d.flags.writes   = 1'b1;
          info_d.flags.mem      = 1'b1;
          info_d.flags.uses_imm = 1'b1;
        end
        5'b01000: begin  // STORE
          case (funct3)
            3'b000:  info_d.instr_name = SB;
            3'b001:  info_d.instr_name = SH;
            3'b010:  info_d.instr_name = SW;
            default: info_d.instr_name = UNKNOWN;
          endcase
          info_d.instr_type     = LS;
          info_d.regs.rs_1      = rs1_idx;
          info_d.regs.rs_2      = rs2_idx;
          info_d.immediate      = imm_s;
          info_d.flags.mem      = 1'b1;
          info_d.flags.uses_imm = 1'b1;
        end
        5'b11000: begin  // BRANCH
          case (funct3)
            3'b000:  info_d.instr_name = BEQ;
            3'b001:  info_d.instr_name = BNE;
            3'b100:  info_d.instr_name = BLT;
            3'b101:  info_d.instr_name = BGE;
            3'b110:  info_d.instr_name = BLTU;
            3'b111:  info_d.instr_name = BGEU;
            default: info_d.instr_name = UNKNOWN;
          endcase
          info_d.instr_type  = BR;
          info_d.regs.rs_1   = rs1_idx;
          info_d.regs.rs_2   = rs2_idx;
          info_d.immediate   = imm_b;
          info_d.flags.jumps = 1'b1;
        end
        5'b11011: begin  // JAL
          info_d.instr_name   = JAL;
          info_d.instr_type   = BR;
          info_d.regs.rd      = rd_idx;
          info_d.immediate    = imm_j;
          info_d.flags.writes = 1'b1;
          info_d.flags.jumps  = 1'b1;
        end
        5'b11001: begin  // JALR
          info_d.instr_name     = (funct3 == 3'b000) ? JALR : UNKNOWN;
          info_d.instr_type     = BR;
          info_d.regs.rd        = rd_idx;
          info_d.regs.rs_1      = rs1_idx;
          info_d.immediate      = imm_i;
          info_d.flags.writes   = 1'b1;
          info_d.flags.jumps    = 1'b1;
          info_d.flags.uses_imm = 1'b1;
        end
        5'b00100: begin  // OP-IMM
          case (funct3)
            3'b000:  info_d.instr_name = ADDI;
            3'b010:  info_d.instr_name = SLTI;
            3'b011:  info_d.instr_name = SLTIU;
            3'b100:  info_d.instr_name = XORI;
            3'b110:  info_d.instr_name = ORI;
            3'b111:  info_d.instr_name = ANDI;
            3'b001:  info_d.instr_name = SLLI;
            default: info_d.instr_name = funct7_5 ? SRAI : SRLI;
          endcase
          info_d.instr_type     = AL;
          info_d.regs.rd        = rd_idx;
          info_d.regs.rs_1      = rs1_idx;
          info_d.immediate      = (funct3[1:0] == 2'b01) ? imm_sh : imm_i;
          info_d.flags.writes   = 1'b1;
          info_d.flags.uses_imm = 1'b1;
        end
        5'b01100: begin  // OP
          case (funct3)
            3'b000:  info_d.instr_name = funct7_5 ? SUB : ADD;
            3'b001:  info_d.instr_name = SLL;
            3'b010:  info_d.instr_name = SLT;
            3'b011:  info_d.instr_name = SLTU;
            3'b100:  info_d.instr_name = XOR;
            3'b101:  info_d.instr_name = funct7_5 ? SRA : SRL;
            3'b110:  info_d.instr_name = OR;
            default: info_d.instr_name = AND;
          endcase
          info_d.instr_type   = AL;
          info_d.regs.rd      = rd_idx;
          info_d.regs.rs_1    = rs1_idx;
          info_d.regs.rs_2    = rs2_idx;
          info_d.flags.writes = 1'b1;
        end
        5'b01101, 5'b00101: begin  // LUI, AUIPC
          info_d.instr_name     = word[5] ? LUI : AUIPC;
          info_d.instr_type     = AL;
          info_d.regs.rd        = rd_idx;
          info_d.immediate      = imm_u;
          info_d.flags.writes   = 1'b1;
          info_d.flags.uses_imm = 1'b1;
        end
        5'b00011: begin  // MISC-MEM, fields stay zero
          info_d.instr_name = (funct3 == 3'b000) ? FENCE : UNKNOWN;
          info_d.instr_type = AL;
        end
        5'b11100: begin  // SYSTEM without CSR
          info_d.instr_type = AL;
          if (word[31:7] == 25'd0) begin
            info_d.instr_name = ECALL;
          end else if (word[31:7] == {12'h001, 13'd0}) begin
            info_d.instr_name = EBREAK;
          end
        end
        default: info_d.instr_name = UNKNOWN;
      endcase
    end
    if (info_d.instr_name == UNKNOWN) begin
      info_d.instr_type = XX;
      info_d.regs       = '0;
      info_d.immediate  = '0;
      info_d.flags      = '0;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      o_info.valid <= 1'b0;
    end else if (!i_stall) begin
      o_info <= info_d;
    end
  end

endmodule

//--- hdl/decoded_bundle_fifo.sv
// Circular FIFO of decoded bundles that drives the output handshake and the pipeline stall
`timescale 1ns/10ps
`include "rv_decode_params.svh"

module decoded_bundle_fifo import rv_decode_pkg::*; (
  input  logic                          i_clock,
  input  logic                          i_rst_n,
  input  instr_info_t [`RV_LANES-1:0]   i_bundle,
  output logic                          o_stall,
  output logic                          o_out_valid,
  input  logic                          i_out_ready,
  output instr_info_t [`RV_LANES-1:0]   o_out_bundle
);

  localparam int PTR_W = $clog2(`RV_FIFO_DEPTH);

  instr_info_t [`RV_LANES-1:0] mem [`RV_FIFO_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [PTR_W:0]              count;
  logic                        any_valid;
  logic                        push;
  logic                        pop;

  always_comb begin
    any_valid = 1'b0;
    for (int k = 0; k < `RV_LANES; k++) begin
      any_valid = any_valid | i_bundle[k].valid;
    end
  end

  assign o_out_valid = (count != '0);
  assign pop         = o_out_valid & i_out_ready;
  assign o_stall     = (count == (PTR_W + 1)'(`RV_FIFO_DEPTH)) & ~pop;
  assign push        = any_valid & ~o_stall;

  // Record valid bits read low while the FIFO is empty
  always_comb begin
    o_out_bundle = mem[rd_ptr];
    for (int k = 0; k < `RV_LANES; k++) begin
      o_out_bundle[k].valid = mem[rd_ptr][k].valid & o_out_valid;
    end
  end

  always_ff @(posedge i_clock) begin
    if (push) begin
      mem[wr_ptr] <= i_bundle;
    end
  end

  always_ff @(posedge i_clock) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hdl/rv_decode_top.sv
// Dual RV32I decode stage top with fetch register, generated decoder lanes and output FIFO
`timescale 1ns/10ps
`include "rv_decode_params.svh"

module rv_decode_top import rv_decode_pkg::*; (
  input  logic                          i_clock,
  input  logic                          i_rst_n,
  input  logic                          i_bundle_valid,
  output logic                          o_bundle_ready,
  input  fetch_slot_t [`RV_LANES-1:0]   i_bundle,
  output logic                          o_out_valid,
  input  logic                          i_out_ready,
  output instr_info_t [`RV_LANES-1:0]   o_out_bundle
);

  fetch_slot_t [`RV_LANES-1:0] slots;
  instr_info_t [`RV_LANES-1:0] dec_bundle;
  logic                        stall;  // Holds every stage

  fetch_bundle_reg i_fetch_bundle_reg (
    .i_clock        (i_clock),
    .i_rst_n        (i_rst_n),
    .i_stall        (stall),
    .i_bundle_valid (i_bundle_valid),
    .o_bundle_ready (o_bundle_ready),
    .i_bundle       (i_bundle),
    .o_slots        (slots)
  );

  for (genvar k = 0; k < `RV_LANES; k++) begin : g_lane
    rv_decoder i_rv_decoder (
      .i_clock (i_clock),
      .i_rst_n (i_rst_n),
      .i_stall (stall),
      .i_slot  (slots[k]),
      .o_info  (dec_bundle[k])
    );
  end

  decoded_bundle_fifo i_decoded_bundle_fifo (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_bundle     (dec_bundle),
    .o_stall      (stall),
    .o_out_valid  (o_out_valid),
    .i_out_ready  (i_out_ready),
    .o_out_bundle (o_out_bundle)
  );

endmodule

//--- testbench/tb_rv_decode_top.sv
// Testbench for the dual RV32I decode stage with directed tests and a reference decoder
`timescale 1ns/10ps
`include "rv_decode_params.svh"

module tb_rv_decode_top import rv_decode_pkg::*; ();

  typedef fetch_slot_t [`RV_LANES-1:0] slot_bundle_t;
  typedef instr_info_t [`RV_LANES-1:0] info_bundle_t;

  localparam int LANES          = `RV_LANES;
  localparam int LATENCY        = 3;                   // Fetch reg, decode reg, FIFO write
  localparam int PENDING_MAX    = `RV_FIFO_DEPTH + 2;  // FIFO plus fetch reg and lanes
  localparam int STREAM_BUNDLES = 60;
  localparam int TEST_CYCLES    = 10 + 4 * 40 + STREAM_BUNDLES * 12;

  logic         i_clock;
  logic         i_rst_n;
  logic         i_bundle_valid;
  logic         o_bundle_ready;
  slot_bundle_t i_bundle;
  logic         o_out_valid;
  logic         i_out_ready;
  info_bundle_t o_out_bundle;

  integer       seed;
  int           errors;
  int           tests;
  int           failed_tests;
  logic [31:0]  next_addr;
  info_bundle_t exp_q[$];  // Bundles in flight with the oldest first
  logic         in_xfer;
  logic         out_xfer;
  logic         seen_out_valid;
  logic         seen_ready;

  rv_decode_top i_rv_decode_top (
    .i_clock        (i_clock),
    .i_rst_n        (i_rst_n),
    .i_bundle_valid (i_bundle_valid),
    .o_bundle_ready (o_bundle_ready),
    .i_bundle       (i_bundle),
    .o_out_valid    (o_out_valid),
    .i_out_ready    (i_out_ready),
    .o_out_bundle   (o_out_bundle)
  );

  initial begin
    i_clock = 1'b0;
    forever #5 i_clock = ~i_clock;
  end

  initial begin
    #(TEST_CYCLES * 20);
    $display("Watchdog expired, tests did not finish within %0d ns", TEST_CYCLES * 20);
    $display("Test failed");
    $finish;
  end

  // Expected record from the RV32I encoding rules
  function automatic instr_info_t ref_decode(input fetch_slot_t s);
    instr_info_t r;
    logic [31:0] w;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    w = s.instr;
    f3 = w[14:12];
    imm_i = 32'($signed(w[31:20]));
    r = '0;
    r.valid = s.valid;
    r.address = s.address;
    r.instr_name = UNKNOWN;
    case (w[6:0])
      7'h03: begin
        case (f3)
          3'd0: r.instr_name = LB;
          3'd1: r.instr_name = LH;
          3'd2: r.instr_name = LW;
          3'd4: r.instr_name = LBU;
          3'd5: r.instr_name = LHU;
          default: r.instr_name = UNKNOWN;
        endcase
      end
      7'h23: begin
        case (f3)
          3'd0: r.instr_name = SB;
          3'd1: r.instr_name = SH;
          3'd2: r.instr_name = SW;
          default: r.instr_name = UNKNOWN;
        endcase
      end
      7'h63: begin
        case (f3)
          3'd0: r.instr_name = BEQ;
          3'd1: r.instr_name = BNE;
          3'd4: r.instr_name = BLT;
          3'd5: r.instr_name = BGE;
          3'd6: r.instr_name = BLTU;
          3'd7: r.instr_name = BGEU;
          default: r.instr_name = UNKNOWN;
        endcase
      end
      7'h6f: r.instr_name = JAL;
      7'h67: if (f3 == 3'd0) r.instr_name = JALR;
      7'h13: begin
        case (f3)
          3'd0: r.instr_name = ADDI;
          3'd1: r.instr_name = SLLI;
          3'd2: r.instr_name = SLTI;
          3'd3: r.instr_name = SLTIU;
          3'd4: r.instr_name = XORI;
          3'd5: r.instr_name = w[30] ? SRAI : SRLI;
          3'd6: r.instr_name = ORI;
          default: r.instr_name = ANDI;
        endcase
      end
      7'h33: begin
        case (f3)
          3'd0: r.instr_name = w[30] ? SUB : ADD;
          3'd1: r.instr_name = SLL;
          3'd2: r.instr_name = SLT;
          3'd3: r.instr_name = SLTU;
          3'd4: r.instr_name = XOR;
          3'd5: r.instr_name = w[30] ? SRA : SRL;
          3'd6: r.instr_name = OR;
          default: r.instr_name = AND;
        endcase
      end
      7'h37: r.instr_name = LUI;
      7'h17: r.instr_name = AUIPC;
      7'h0f: if (f3 == 3'd0) r.instr_name = FENCE;
      7'h73: begin
        if (w == 32'h00000073) r.instr_name = ECALL;
        else if (w == 32'h00100073) r.instr_name = EBREAK;
      end
      default: r.instr_name = UNKNOWN;
    endcase
    // Flags are writes, jumps, mem, uses_imm
    case (r.instr_name)
      LB, LH, LW, LBU, LHU: begin
        r.instr_type = LS;
        r.regs = {w[11:7], w[19:15], 5'd0};
        r.immediate = imm_i;
        r.flags = 4'b1011;
      end
      SB, SH, SW: begin
        r.instr_type = LS;
        r.regs = {5'd0, w[19:15], w[24:20]};
        r.immediate = 32'($signed({w[31:25], w[11:7]}));
        r.flags = 4'b0011;
      end
      BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
        r.instr_type = BR;
        r.regs = {5'd0, w[19:15], w[24:20]};
        r.immediate = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        r.flags = 4'b0100;
      end
      JAL: begin
        r.instr_type = BR;
        r.regs = {w[11:7], 10'd0};
        r.immediate = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        r.flags = 4'b1100;
      end
      JALR: begin
        r.instr_type = BR;
        r.regs = {w[11:7], w[19:15], 5'd0};
        r.immediate = imm_i;
        r.flags = 4'b1101;
      end
      ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI: begin
        r.instr_type = AL;
        r.regs = {w[11:7], w[19:15], 5'd0};
        r.immediate = (f3 == 3'd1 || f3 == 3'd5) ? 32'(w[24:20]) : imm_i;
        r.flags = 4'b1001;
      end
      ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND: begin
        r.instr_type = AL;
        r.regs = {w[11:7], w[19:15], w[24:20]};
        r.flags = 4'b1000;
      end
      LUI, AUIPC: begin
        r.instr_type = AL;
        r.regs = {w[11:7], 10'd0};
        r.immediate = {w[31:12], 12'd0};
        r.flags = 4'b1001;
      end
      FENCE, ECALL, EBREAK: r.instr_type = AL;
      default: r.instr_type = XX;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd9, 5'd8, f3, 5'd7, 7'h33};  // rs2 x9, rs1 x8, rd x7
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [2:0] f3);
    return {imm, 5'd8, f3, 5'd7, 7'h13};
  endfunction

  task automatic compare_info(input string name, input instr_info_t exp, input instr_info_t act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_valid(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic report_test(input string name, input int start);
    tests++;
    if (errors == start) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, errors - start);
    end
  endtask

  // Legal RV32I word with random fields
  task automatic random_word(output logic [31:0] w);
    logic [31:0] r;
    logic [2:0]  f3;
    r = $random(seed);
    w = $random(seed);
    f3 = r[6:4];
    case (r[31:28] % 4'd10)
      4'd0: begin
        f3 = r[6:4] % 3'd5;
        if (f3 > 3'd2) f3 = f3 + 3'd1;
        w[6:0] = 7'h03;
      end
      4'd1: begin
        f3 = {1'b0, r[5:4]};
        if (f3 == 3'd3) f3 = 3'd2;
        w[6:0] = 7'h23;
      end
      4'd2: begin
        if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // Skip the two reserved funct3
        w[6:0] = 7'h63;
      end
      4'd3: w[6:0] = 7'h6f;
      4'd4: begin
        f3 = 3'd0;
        w[6:0] = 7'h67;
      end
      4'd5: begin
        if (f3 == 3'd1) w[31:25] = 7'd0;
        if (f3 == 3'd5) w[31:25] = {1'b0, r[8], 5'd0};
        w[6:0] = 7'h13;
      end
      4'd6: begin
        w[31:25] = (f3 == 3'd0 || f3 == 3'd5) ? {1'b0, r[8], 5'd0} : 7'd0;
        w[6:0] = 7'h33;
      end
      4'd7: w[6:0] = 7'h37;
      4'd8: w[6:0] = 7'h17;
      default: begin
        f3 = 3'd0;
        case (r[1:0])
          2'd0: w = 32'h0ff0000f;
          2'd1: w = 32'h00000073;
          2'd2: w = 32'h00100073;
          default: w[6:0] = 7'h0f;
        endcase
      end
    endcase
    if (w[6:0] != 7'h6f && w[6:0] != 7'h37 && w[6:0] != 7'h17 && w[6:0] != 7'h73) begin
      w[14:12] = f3;
    end
  endtask

  task automatic random_bundle(input logic all_valid, output slot_bundle_t b);
    logic [31:0] rnd;
    logic [31:0] w;
    for (int k = 0; k < LANES; k++) begin
      rnd = $random(seed);
      random_word(w);
      b[k].valid = all_valid | (rnd[2:0] != 3'd0);
      b[k].address = next_addr;
      b[k].instr = w;
      next_addr = next_addr + 32'd4;
    end
  endtask

  task automatic expect_bundle(input slot_bundle_t b);
    info_bundle_t e;
    logic         any_valid;
    any_valid = 1'b0;
    for (int k = 0; k < LANES; k++) begin
      e[k] = ref_decode(b[k]);
      any_valid = any_valid | b[k].valid;
    end
    if (any_valid) exp_q.push_back(e);  // Empty bundles never reach the FIFO
  endtask

  task automatic check_output();
    info_bundle_t e;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Output bundle arrived when none was expected");
    end else begin
      e = exp_q.pop_front();
      for (int k = 0; k < LANES; k++) begin
        compare_info($sformatf("o_out_bundle[%0d]", k), e[k], o_out_bundle[k]);
      end
    end
  endtask

  // Starts at a falling edge with inputs set and returns at the next one
  task automatic step_cycle();
    #1;
    in_xfer = i_bundle_valid & o_bundle_ready;
    out_xfer = o_out_valid & i_out_ready;
    seen_out_valid = o_out_valid;
    seen_ready = o_bundle_ready;
    if (in_xfer) expect_bundle(i_bundle);
    if (out_xfer) check_output();
    @(negedge i_clock);
  endtask

  task automatic send_bundle(input slot_bundle_t b);
    int waited;
    waited = 0;
    i_bundle = b;
    i_bundle_valid = 1'b1;
    step_cycle();
    while (!in_xfer && waited < 50) begin
      waited++;
      step_cycle();
    end
    if (!in_xfer) begin
      errors++;
      $display("Input bundle was not accepted within 50 cycles");
    end
    i_bundle_valid = 1'b0;
  endtask

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (exp_q.size() > 0 && waited < 100) begin
      step_cycle();
      waited++;
    end
    if (exp_q.size() > 0) begin
      errors++;
      $display("%0d expected bundles never arrived", exp_q.size());
      exp_q.delete();
    end
    repeat (3) step_cycle();  // Catch a duplicated bundle
  endtask

  task automatic send_words(input logic [31:0] words[$]);
    slot_bundle_t b;
    int           idx;
    idx = 0;
    i_out_ready = 1'b1;
    while (idx < words.size()) begin
      for (int k = 0; k < LANES; k++) begin
        b[k].valid = (idx < words.size());
        b[k].address = next_addr;
        b[k].instr = (idx < words.size()) ? words[idx] : 32'd0;
        next_addr = next_addr + 32'd4;
        idx++;
      end
      send_bundle(b);
    end
    drain_outputs();
  endtask

  task automatic check_reset_state();
    int start;
    start = errors;
    step_cycle();
    compare_valid("o_out_valid", 1'b0, seen_out_valid);
    compare_valid("o_bundle_ready", 1'b1, seen_ready);
    for (int k = 0; k < LANES; k++) begin
      compare_valid($sformatf("o_out_bundle[%0d].valid", k), 1'b0, o_out_bundle[k].valid);
    end
    report_test("check_reset_state", start);
  endtask

  task automatic measure_latency();
    slot_bundle_t b;
    int           start;
    int           lat;
    start = errors;
    i_out_ready = 1'b1;
    random_bundle(1'b1, b);
    send_bundle(b);
    lat = 1;  // Transfer edge is the first cycle
    step_cycle();
    while (!seen_out_valid && lat < 10) begin
      lat++;
      step_cycle();
    end
    if (lat != LATENCY) begin
      errors++;
      $display("ERR latency expected %h actual %h", LATENCY, lat);
    end
    drain_outputs();
    report_test("measure_latency", start);
  endtask

  task automatic decode_formats();
    logic [31:0] words[$];
    int          start;
    start = errors;
    // LW, SH, BNE -8, JAL, JALR, LUI, AUIPC, SRAI
    words = '{32'hffc12283, 32'h00719523, 32'hfe209ce3, 32'h001000ef,
              32'h00008067, 32'h12345537, 32'hfffff197, 32'h4033d313};
    send_words(words);
    report_test("decode_formats", start);
  endtask

  task automatic decode_names();
    logic [31:0] words[$];
    int          start;
    start = errors;
    for (int f = 0; f < 8; f++) begin
      words.push_back(encode_r(7'h00, 3'(f)));
      if (f == 1) begin
        words.push_back(encode_i(12'h01f, 3'(f)));
      end else if (f == 5) begin
        words.push_back(encode_i(12'h00d, 3'(f)));  // SRLI
        words.push_back(encode_i(12'h40d, 3'(f)));  // SRAI
      end else begin
        words.push_back(encode_i(12'h8a5, 3'(f)));
      end
    end
    words.push_back(encode_r(7'h20, 3'd0));
    words.push_back(encode_r(7'h20, 3'd5));
    words.push_back(32'h0ff0000f);
    words.push_back(32'h00000073);
    words.push_back(32'h00100073);
    send_words(words);
    report_test("decode_names", start);
  endtask

  task automatic decode_unknown();
    logic [31:0]  words[$];
    slot_bundle_t b;
    int           start;
    start = errors;
    // Zero, two undefined opcodes, CSRRS, LOAD and JALR with reserved funct3
    words = '{32'h00000000, 32'hfedcbaff, 32'h1234560b, 32'h3412a073,
              32'hfff13283, 32'h0041d0e7};
    send_words(words);
    random_bundle(1'b1, b);
    b[1].valid = 1'b0;
    send_bundle(b);
    drain_outputs();
    report_test("decode_unknown", start);
  endtask

  task automatic stream_backpressure();
    slot_bundle_t b;
    logic [31:0]  rnd;
    logic         exp_ready;
    int           start;
    int           sent;
    int           hold;
    int           guard;
    start = errors;
    sent = 0;
    hold = 0;
    guard = 0;
    i_out_ready = 1'b0;
    random_bundle(1'b1, b);
    i_bundle = b;
    i_bundle_valid = 1'b1;
    // Output held off until the pipeline fills
    repeat (PENDING_MAX + 3) begin
      exp_ready = (sent < PENDING_MAX);
      step_cycle();
      compare_valid("o_bundle_ready", exp_ready, seen_ready);
      if (in_xfer) begin
        sent++;
        random_bundle(1'b1, b);
        i_bundle = b;
      end
    end
    while (sent < STREAM_BUNDLES && guard < STREAM_BUNDLES * 10) begin
      if (hold == 0) begin
        i_out_ready = ~i_out_ready;
        rnd = $random(seed);
        hold = i_out_ready ? 1 + int'(rnd[1:0]) : 4 + int'(rnd[3:0]);  // Long low stretches
      end
      hold--;
      step_cycle();
      guard++;
      if (in_xfer) begin
        sent++;
        random_bundle(1'b0, b);
        i_bundle = b;
      end
    end
    if (sent < STREAM_BUNDLES) begin
      errors++;
      $display("Input stalled with %0d of %0d bundles sent", sent, STREAM_BUNDLES);
    end
    i_bundle_valid = 1'b0;
    i_out_ready = 1'b1;
    drain_outputs();
    report_test("stream_backpressure", start);
  endtask

  initial begin
    seed = 31662;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    next_addr = 32'h0000_1000;
    i_rst_n = 1'b0;
    i_bundle_valid = 1'b0;
    i_bundle = '0;
    i_out_ready = 1'b1;
    repeat (10) @(negedge i_clock);
    i_rst_n = 1'b1;
    check_reset_state();
    measure_latency();
    decode_formats();
    decode_names();
    decode_unknown();
    stream_backpressure();
    $display("Tests run %0d, failing %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+include
hdl/rv_decode_pkg.sv
hdl/fetch_bundle_reg.sv
hdl/rv_decoder.sv
hdl/decoded_bundle_fifo.sv
hdl/rv_decode_top.sv
testbench/tb_rv_decode_top.sv

//--- Makefile
# Verilator flow for the dual RV32I decode stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module rv_decode_top

sim:
	verilator --binary --timing -j 0 -f build.f --top-module tb_rv_decode_top -o sim_tb
	./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
